//--- hdl/rv_pkg.sv
/*
 * RV32I execute stage shared definitions
 * Data and instruction word types, major opcode and ALU operation
 * encodings, and the default queue sizes used by the top level
 */

package rv_pkg;

    // ------------------------------------------------------------
    // Word types
    // ------------------------------------------------------------

    // Data word: pc, operands, immediate and result
    typedef logic [31:0] xlen_t;

    // Raw instruction word
    typedef logic [31:0] instr_t;

    // ------------------------------------------------------------
    // Major opcodes, instr[6:0]
    // ------------------------------------------------------------

    typedef enum logic [6:0] {
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        IMM_ALU = 7'b0010011,
        REG_ALU = 7'b0110011
    } opcode_e;

    // ------------------------------------------------------------
    // ALU operations
    // ------------------------------------------------------------

    // Encoded as {funct7[5], funct3}
    typedef enum logic [3:0] {
        OP_ADD  = 4'b0000,
        OP_SUB  = 4'b1000,
        OP_SLL  = 4'b0001,
        OP_SLT  = 4'b0010,
        OP_SLTU = 4'b0011,
        OP_XOR  = 4'b0100,
        OP_SRL  = 4'b0101,
        OP_SRA  = 4'b1101,
        OP_OR   = 4'b0110,
        OP_AND  = 4'b0111
    } alu_op_e;

    // ------------------------------------------------------------
    // Queue defaults
    // ------------------------------------------------------------

    // Entries in the issue queue, also the upstream credit count
    localparam int IQ_DEPTH_DEF    = 4;
    // Entries in the result queue
    localparam int RQ_DEPTH_DEF    = 4;
    // Downstream credits held after reset
    localparam int OUT_CREDITS_DEF = 2;

endpackage

//--- hdl/alu.sv
/*
 * Integer ALU
 * Purely combinational, covers the ten RV32I register operations.
 * Shift amount comes from the low bits of b, undefined codes give zero
 */

module alu #(
    parameter int WIDTH = 32
) (
    input  rv_pkg::xlen_t   a,
    input  rv_pkg::xlen_t   b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::xlen_t   result
);

    import rv_pkg::*;

    // Shift amount width, five bits for a 32-bit word
    localparam int SHW = $clog2(WIDTH);

    logic [SHW-1:0] shamt;

    assign shamt = b[SHW-1:0];

    always_comb begin
        case (op)
            // Arithmetic
            OP_ADD:  result = a + b;
            OP_SUB:  result = a - b;

            // Shifts
            OP_SLL:  result = a << shamt;
            OP_SRL:  result = a >> shamt;
            OP_SRA:  result = xlen_t'($signed(a) >>> shamt);

            // Set less than, signed and unsigned
            OP_SLT: begin
                result = '0;
                result[0] = ($signed(a) < $signed(b));
            end
            OP_SLTU: begin
                result = '0;
                result[0] = (a < b);
            end

            // Bitwise logic
            OP_XOR:  result = a ^ b;
            OP_OR:   result = a | b;
            OP_AND:  result = a & b;

            // Codes outside the set
            default: result = '0;
        endcase
    end

endmodule

//--- hdl/issue_queue.sv
/*
 * Issue queue
 * Circular buffer for incoming instructions and their operands.
 * Upstream spends one credit per write; a registered credit pulse
 * goes back for every entry popped by the executer
 */

module issue_queue #(
    parameter int DEPTH = 4
) (
    input  logic           clk,
    input  logic           rst,
    // Upstream side
    input  logic           in_valid,
    input  rv_pkg::instr_t in_instr,
    input  rv_pkg::xlen_t  in_pc,
    input  rv_pkg::xlen_t  in_rs1,
    input  rv_pkg::xlen_t  in_rs2,
    input  rv_pkg::xlen_t  in_imm,
    output logic           in_credit,
    // Executer side
    output logic           iq_valid,
    output rv_pkg::instr_t iq_instr,
    output rv_pkg::xlen_t  iq_pc,
    output rv_pkg::xlen_t  iq_rs1,
    output rv_pkg::xlen_t  iq_rs2,
    output rv_pkg::xlen_t  iq_imm,
    input  logic           iq_pop
);

    import rv_pkg::*;

    localparam int PW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    // Storage, one array per field
    instr_t mem_instr [DEPTH];
    xlen_t  mem_pc    [DEPTH];
    xlen_t  mem_rs1   [DEPTH];
    xlen_t  mem_rs2   [DEPTH];
    xlen_t  mem_imm   [DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    // Wraps at DEPTH, so odd depths work too
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        if (p == PW'(DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    // Write guarded against overflow, credits should prevent it anyway
    assign push = in_valid && (count != CW'(DEPTH));
    assign pop  = iq_pop && iq_valid;

    // ------------------------------------------------------------
    // Pointers, count and credit return
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            count     <= count + CW'(push) - CW'(pop);
            // One credit back per released slot
            in_credit <= pop;
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem_instr[wr_ptr] <= in_instr;
            mem_pc[wr_ptr]    <= in_pc;
            mem_rs1[wr_ptr]   <= in_rs1;
            mem_rs2[wr_ptr]   <= in_rs2;
            mem_imm[wr_ptr]   <= in_imm;
        end
    end

    // Head of queue, shown to the executer
    assign iq_valid = (count != '0);
    assign iq_instr = mem_instr[rd_ptr];
    assign iq_pc    = mem_pc[rd_ptr];
    assign iq_rs1   = mem_rs1[rd_ptr];
    assign iq_rs2   = mem_rs2[rd_ptr];
    assign iq_imm   = mem_imm[rd_ptr];

endmodule

//--- hdl/executer.sv
/*
 * Instruction executer
 * Picks ALU operands and operation from opcode and funct fields,
 * resolves branch conditions and registers result, taken flag and pc.
 * Pops the issue queue whenever the result queue has room
 */

module executer (
    input  logic           clk,
    input  logic           rst,
    // Issue queue side
    input  logic           iq_valid,
    input  rv_pkg::instr_t iq_instr,
    input  rv_pkg::xlen_t  iq_pc,
    input  rv_pkg::xlen_t  iq_rs1,
    input  rv_pkg::xlen_t  iq_rs2,
    input  rv_pkg::xlen_t  iq_imm,
    output logic           iq_pop,
    // Result queue side
    input  logic           rq_ready,
    output logic           ex_valid,
    output rv_pkg::xlen_t  ex_result,
    output logic           ex_taken,
    output rv_pkg::xlen_t  ex_pc
);

    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    xlen_t      alu_a;
    xlen_t      alu_b;
    alu_op_e    operation;
    xlen_t      alu_result;
    logic       taken;

    // Instruction fields
    assign opcode    = opcode_e'(iq_instr[6:0]);
    assign funct3    = iq_instr[14:12];
    assign funct7_b5 = iq_instr[30];

    // ------------------------------------------------------------
    // Operand select, operation decode, branch condition
    // ------------------------------------------------------------
    always_comb begin
        alu_a     = iq_rs1;
        alu_b     = iq_imm;
        operation = OP_ADD;
        taken     = 1'b0;

        case (opcode)
            // Address generation, rs1 + imm
            LOAD, STORE: ;

            // Immediate passes through unchanged
            LUI:
                alu_a = '0;

            // pc relative, AUIPC stays not taken
            AUIPC:
                alu_a = iq_pc;

            JAL: begin
                alu_a = iq_pc;
                taken = 1'b1;
            end

            // Target from rs1 + imm
            JALR:
                taken = 1'b1;

            // Bit 30 only selects SRA over SRL here
            IMM_ALU: begin
                if (funct3 == 3'b101)
                    operation = alu_op_e'({funct7_b5, funct3});
                else
                    operation = alu_op_e'({1'b0, funct3});
            end

            REG_ALU: begin
                alu_b     = iq_rs2;
                operation = alu_op_e'({funct7_b5, funct3});
            end

            // Target pc + imm, condition on rs1 vs rs2
            BRANCH: begin
                alu_a = iq_pc;
                case (funct3)
                    3'b000:  taken = (iq_rs1 == iq_rs2);
                    3'b001:  taken = (iq_rs1 != iq_rs2);
                    3'b100:  taken = ($signed(iq_rs1) <  $signed(iq_rs2));
                    3'b101:  taken = ($signed(iq_rs1) >= $signed(iq_rs2));
                    3'b110:  taken = (iq_rs1 <  iq_rs2);  // BLTU
                    3'b111:  taken = (iq_rs1 >= iq_rs2);  // BGEU
                    default: taken = 1'b0;
                endcase
            end

            default: ;
        endcase
    end

    alu #(
        .WIDTH  ($bits(xlen_t))
    ) alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .op     (operation),
        .result (alu_result)
    );

    // ------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------

    // Stage drains into the result queue every cycle, rq_ready
    // already counts the entry held here
    assign iq_pop = iq_valid && rq_ready;

    always_ff @(posedge clk) begin
        if (rst)
            ex_valid <= 1'b0;
        else
            ex_valid <= iq_pop;
    end

    // Payload
    always_ff @(posedge clk) begin
        if (iq_pop) begin
            ex_result <= alu_result;
            ex_taken  <= taken;
            ex_pc     <= iq_pc;
        end
    end

endmodule

//--- hdl/result_queue.sv
/*
 * Result queue
 * FIFO for executed results with a downstream credit counter.
 * One entry leaves per cycle while a credit is held; rq_ready
 * includes the entry waiting in the executer stage
 */

module result_queue #(
    parameter int DEPTH   = 4,
    parameter int CREDITS = 2
) (
    input  logic          clk,
    input  logic          rst,
    // Executer side
    input  logic          ex_valid,
    input  rv_pkg::xlen_t ex_result,
    input  logic          ex_taken,
    input  rv_pkg::xlen_t ex_pc,
    output logic          rq_ready,
    // Downstream side
    output logic          out_valid,
    output rv_pkg::xlen_t out_result,
    output logic          out_taken,
    output rv_pkg::xlen_t out_pc,
    input  logic          out_credit
);

    import rv_pkg::*;

    localparam int PW  = $clog2(DEPTH);
    localparam int CW  = $clog2(DEPTH + 1);
    localparam int CRW = $clog2(CREDITS + 1);

    xlen_t mem_result [DEPTH];
    logic  mem_taken  [DEPTH];
    xlen_t mem_pc     [DEPTH];

    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic [CW:0]    occupancy;
    logic [CRW-1:0] credits;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        if (p == PW'(DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    // Queued entries plus the one in flight from the executer
    assign occupancy = (CW + 1)'(count) + (CW + 1)'(ex_valid);
    assign rq_ready  = (occupancy < (CW + 1)'(DEPTH));

    // Send whenever something is queued and a credit is held
    assign out_valid = (count != '0) && (credits != '0);

    // ------------------------------------------------------------
    // Pointers, count and credits
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRW'(CREDITS);
        end else begin
            if (ex_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (out_valid)
                rd_ptr <= next_ptr(rd_ptr);
            count   <= count + CW'(ex_valid) - CW'(out_valid);
            // Spent on send, returned by out_credit
            credits <= credits - CRW'(out_valid) + CRW'(out_credit);
        end
    end

    // Entry storage, space guaranteed by rq_ready
    always_ff @(posedge clk) begin
        if (ex_valid) begin
            mem_result[wr_ptr] <= ex_result;
            mem_taken[wr_ptr]  <= ex_taken;
            mem_pc[wr_ptr]     <= ex_pc;
        end
    end

    assign out_result = mem_result[rd_ptr];
    assign out_taken  = mem_taken[rd_ptr];
    assign out_pc     = mem_pc[rd_ptr];

endmodule

//--- hdl/ex_top.sv
/*
 * Execute stage top level
 * Issue queue, executer and result queue in a row, credit
 * handshake on both outside interfaces
 */

module ex_top #(
    parameter int IQ_DEPTH    = rv_pkg::IQ_DEPTH_DEF,
    parameter int RQ_DEPTH    = rv_pkg::RQ_DEPTH_DEF,
    parameter int OUT_CREDITS = rv_pkg::OUT_CREDITS_DEF
) (
    input  logic           clk,
    input  logic           rst,
    // Issue stage
    input  logic           in_valid,
    input  rv_pkg::instr_t in_instr,
    input  rv_pkg::xlen_t  in_pc,
    input  rv_pkg::xlen_t  in_rs1,
    input  rv_pkg::xlen_t  in_rs2,
    input  rv_pkg::xlen_t  in_imm,
    output logic           in_credit,
    // Downstream
    output logic           out_valid,
    output rv_pkg::xlen_t  out_result,
    output logic           out_taken,
    output rv_pkg::xlen_t  out_pc,
    input  logic           out_credit
);

    import rv_pkg::*;

    // ------------------------------------------------------------
    // Issue queue to executer
    // ------------------------------------------------------------
    logic   iq_valid;
    instr_t iq_instr;
    xlen_t  iq_pc;
    xlen_t  iq_rs1;
    xlen_t  iq_rs2;
    xlen_t  iq_imm;
    logic   iq_pop;

    // Executer to result queue
    logic   rq_ready;
    logic   ex_valid;
    xlen_t  ex_result;
    logic   ex_taken;
    xlen_t  ex_pc;

    issue_queue #(
        .DEPTH     (IQ_DEPTH)
    ) issue_queue_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_pc     (in_pc),
        .in_rs1    (in_rs1),
        .in_rs2    (in_rs2),
        .in_imm    (in_imm),
        .in_credit (in_credit),
        .iq_valid  (iq_valid),
        .iq_instr  (iq_instr),
        .iq_pc     (iq_pc),
        .iq_rs1    (iq_rs1),
        .iq_rs2    (iq_rs2),
        .iq_imm    (iq_imm),
        .iq_pop    (iq_pop)
    );

    executer executer_i (
        .clk       (clk),
        .rst       (rst),
        .iq_valid  (iq_valid),
        .iq_instr  (iq_instr),
        .iq_pc     (iq_pc),
        .iq_rs1    (iq_rs1),
        .iq_rs2    (iq_rs2),
        .iq_imm    (iq_imm),
        .iq_pop    (iq_pop),
        .rq_ready  (rq_ready),
        .ex_valid  (ex_valid),
        .ex_result (ex_result),
        .ex_taken  (ex_taken),
        .ex_pc     (ex_pc)
    );

    result_queue #(
        .DEPTH      (RQ_DEPTH),
        .CREDITS    (OUT_CREDITS)
    ) result_queue_i (
        .clk        (clk),
        .rst        (rst),
        .ex_valid   (ex_valid),
        .ex_result  (ex_result),
        .ex_taken   (ex_taken),
        .ex_pc      (ex_pc),
        .rq_ready   (rq_ready),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_taken  (out_taken),
        .out_pc     (out_pc),
        .out_credit (out_credit)
    );

endmodule

//--- tests/ex_top_props.sv
/*
 * Execute stage credit properties
 * Tracks both credit handshakes from the outside ports and checks
 * the upstream and downstream credit rules and the reset state
 */

module ex_top_props #(
    parameter int IQ_DEPTH    = rv_pkg::IQ_DEPTH_DEF,
    parameter int OUT_CREDITS = rv_pkg::OUT_CREDITS_DEF
) (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic in_credit,
    input logic out_valid,
    input logic out_credit
);

    // Issue queue slots not yet handed back to upstream
    int iq_used;
    // Downstream credits the result queue should hold
    int out_held;

    always_ff @(posedge clk) begin
        if (rst) begin
            iq_used  <= 0;
            out_held <= OUT_CREDITS;
        end else begin
            iq_used  <= iq_used + int'(in_valid) - int'(in_credit);
            out_held <= out_held - int'(out_valid) + int'(out_credit);
        end
    end

    // ------------------------------------------------------------
    // Credit rules
    // ------------------------------------------------------------
    no_iq_overflow: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> iq_used < IQ_DEPTH)
        else $error("in_valid arrived while the issue queue was full");

    no_send_without_credit: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> out_held > 0)
        else $error("out_valid raised with no downstream credit");

    // Quiet outputs once reset has been seen for a full cycle
    quiet_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !in_credit && !out_valid)
        else $error("in_credit or out_valid active during reset");

endmodule

bind ex_top ex_top_props #(
    .IQ_DEPTH    (IQ_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
) props_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit)
);

//--- tests/tb_ex_top.sv
/*
 * Execute stage testbench
 * Reads instructions and expected results from the stimulus file,
 * sends them under the upstream credit rule, returns downstream
 * credits with random or prompt delays and checks results in order
 */

module tb_ex_top;

    import rv_pkg::*;

    localparam int          CLK_PERIOD     = 4;
    localparam int          RESET_CYCLES   = 5;
    localparam int          IQ_CREDITS     = IQ_DEPTH_DEF;
    localparam int          PASSES         = 2;
    localparam int          CYCLES_PER_LINE = 40;
    localparam int          WATCHDOG_SLACK = 200;
    localparam logic [31:0] LFSR_SEED      = 32'd66004;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS      = 32'h80200003;
    localparam string       STIM_FILE      = "tests/ex_stimulus.txt";

    logic   clk;
    logic   rst;
    logic   in_valid;
    instr_t in_instr;
    xlen_t  in_pc;
    xlen_t  in_rs1;
    xlen_t  in_rs2;
    xlen_t  in_imm;
    logic   in_credit;
    logic   out_valid;
    xlen_t  out_result;
    logic   out_taken;
    xlen_t  out_pc;
    logic   out_credit;

    // Stimulus table with one entry per file line
    instr_t stim_instr [$];
    xlen_t  stim_pc [$];
    xlen_t  stim_rs1 [$];
    xlen_t  stim_rs2 [$];
    xlen_t  stim_imm [$];
    xlen_t  stim_result [$];
    logic   stim_taken [$];
    int     idle_gap [$];
    int     num_lines;

    // Expected results in send order
    xlen_t exp_result_q [$];
    logic  exp_taken_q [$];
    xlen_t exp_pc_q [$];

    int          in_credits;
    int          owed_credits;
    int          sent;
    int          checked;
    bit          slow_credit;
    bit          loaded;
    logic [31:0] lfsr_state;

    ex_top DUT (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_pc      (in_pc),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_imm     (in_imm),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_taken  (out_taken),
        .out_pc     (out_pc),
        .out_credit (out_credit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_word(input string name, input xlen_t expected, input xlen_t actual);
        if (actual !== expected)
            abort_run($sformatf("MISMATCH time=%0t signal=%s expected=%08h actual=%08h",
                $time, name, expected, actual));
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abort_run($sformatf("MISMATCH time=%0t signal=%s expected=%b actual=%b",
                $time, name, expected, actual));
    endtask

    // Galois form shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ LFSR_TAPS;
        return state >> 1;
    endfunction

    // One LFSR step per bit
    function automatic int unsigned random_bits(input int count);
        int unsigned value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | {31'b0, lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        instr_t      instr;
        xlen_t       pc;
        xlen_t       rs1;
        xlen_t       rs2;
        xlen_t       imm;
        xlen_t       result;
        logic [31:0] taken_word;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
            abort_run("ERROR: stimulus file could not be opened");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Blank and comment lines
            if (line.len() <= 1 || line.getc(0) == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                instr, pc, rs1, rs2, imm, result, taken_word);
            if (n != 7) begin
                abort_run($sformatf("ERROR: stimulus line not readable: %s", line));
            end else begin
                stim_instr.push_back(instr);
                stim_pc.push_back(pc);
                stim_rs1.push_back(rs1);
                stim_rs2.push_back(rs2);
                stim_imm.push_back(imm);
                stim_result.push_back(result);
                stim_taken.push_back(taken_word[0]);
            end
        end
        $fclose(fd);
        num_lines = stim_instr.size();
    endtask

    // Waits for an upstream credit, then drives one instruction for a cycle
    task automatic send_line(input int idx);
        while (in_credits == 0) begin
            @(posedge clk);
            #1;
        end
        in_valid   = 1'b1;
        in_instr   = stim_instr[idx];
        in_pc      = stim_pc[idx];
        in_rs1     = stim_rs1[idx];
        in_rs2     = stim_rs2[idx];
        in_imm     = stim_imm[idx];
        in_credits = in_credits - 1;
        exp_result_q.push_back(stim_result[idx]);
        exp_taken_q.push_back(stim_taken[idx]);
        exp_pc_q.push_back(stim_pc[idx]);
        sent = sent + 1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic check_output();
        xlen_t exp_result;
        logic  exp_taken;
        xlen_t exp_pc;
        if (exp_result_q.size() == 0) begin
            abort_run("ERROR: a result came out with no instruction outstanding");
        end else begin
            exp_result = exp_result_q.pop_front();
            exp_taken  = exp_taken_q.pop_front();
            exp_pc     = exp_pc_q.pop_front();
            compare_word("out_result", exp_result, out_result);
            compare_flag("out_taken", exp_taken, out_taken);
            compare_word("out_pc", exp_pc, out_pc);
            checked      = checked + 1;
            owed_credits = owed_credits + 1;
        end
    endtask

    // ------------------------------------------------------------
    // Output monitor and upstream credit count at mid cycle
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst && in_credit) begin
            in_credits = in_credits + 1;
            if (in_credits > IQ_CREDITS)
                abort_run("ERROR: upstream credits exceed the issue queue depth");
        end
        if (!rst && out_valid)
            check_output();
    end

    // Downstream credit return with one pulse per result
    initial begin : credit_return
        int gap;
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_credit = 1'b0;
            if (owed_credits > 0) begin
                gap = 0;
                // Long random holds give back-pressure
                if (slow_credit)
                    gap = int'(random_bits(5));
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                out_credit   = 1'b1;
                owed_credits = owed_credits - 1;
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (CYCLES_PER_LINE * PASSES * num_lines + WATCHDOG_SLACK) @(posedge clk);
        abort_run("ERROR: outputs stalled before all results arrived");
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin : main
        clk          = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        in_pc        = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        in_imm       = '0;
        in_credits   = IQ_CREDITS;
        owed_credits = 0;
        sent         = 0;
        checked      = 0;
        slow_credit  = 1'b1;
        loaded       = 1'b0;
        lfsr_state   = LFSR_SEED;
        num_lines    = 0;

        load_stimulus();
        if (num_lines == 0)
            abort_run("ERROR: stimulus file holds no instructions");
        // Idle gaps for the first pass are drawn up front
        for (int i = 0; i < num_lines; i++)
            idle_gap.push_back(int'(random_bits(2)));
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // Pass one with random gaps and slow credit return
        for (int i = 0; i < num_lines; i++) begin
            repeat (idle_gap[i]) begin
                @(posedge clk);
                #1;
            end
            send_line(i);
        end
        wait (checked == sent);
        @(posedge clk);
        #1;

        // Pass two runs back to back with prompt credits
        slow_credit = 1'b0;
        for (int i = 0; i < num_lines; i++)
            send_line(i);
        wait (checked == sent);

        if (in_credits != IQ_CREDITS) begin
            abort_run("ERROR: upstream credits not all returned at the end");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- tests/ex_stimulus.txt
# instr    pc       rs1      rs2      imm      result   taken
# All fields hex, one instruction per line, sent in file order
000000B3 00001000 00000005 00000007 00000000 0000000C 0
400000B3 00001004 00000005 00000007 00000000 FFFFFFFE 0
000010B3 00001008 00000003 00000024 00000000 00000030 0
000020B3 0000100C FFFFFFFF 00000001 00000000 00000001 0
000030B3 00001010 FFFFFFFF 00000001 00000000 00000000 0
000040B3 00001014 F0F0F0F0 FF00FF00 00000000 0FF00FF0 0
000050B3 00001018 80000000 00000004 00000000 08000000 0
400050B3 0000101C 80000000 00000004 00000000 F8000000 0
000060B3 00001020 F0F0F0F0 0F00FF00 00000000 FFF0FFF0 0
000070B3 00001024 F0F0F0F0 FF00FF00 00000000 F000F000 0
00000093 00001028 00000010 00000000 FFFFFFFF 0000000F 0
40000093 0000102C 00000010 00000000 00000400 00000410 0
00002093 00001030 FFFFFFFE 00000000 00000003 00000001 0
00003093 00001034 FFFFFFFE 00000000 00000003 00000000 0
40005093 00001038 80000010 00000000 00000404 F8000001 0
00004093 0000103C 12345678 00000000 FFFFFFFF EDCBA987 0
00002083 00002000 00001000 00000000 FFFFFFFC 00000FFC 0
00002023 00002004 00003000 DEADBEEF 00000010 00003010 0
000000B7 00002008 11111111 00000000 ABCDE000 ABCDE000 0
00000097 0000200C 00000000 00000000 00001000 0000300C 0
000000EF 00002010 00000000 00000000 00000100 00002110 1
000000E7 00002014 00004000 00000000 FFFFFFF0 00003FF0 1
00000063 00003000 00000005 00000005 00000020 00003020 1
00000063 00003004 00000005 00000006 00000020 00003024 0
00001063 00003008 00000005 00000006 00000020 00003028 1
00001063 0000300C 00000005 00000005 00000020 0000302C 0
00004063 00003010 FFFFFFFF 00000001 00000020 00003030 1
00004063 00003014 00000001 FFFFFFFF 00000020 00003034 0
00005063 00003018 00000001 FFFFFFFF 00000020 00003038 1
00005063 0000301C FFFFFFFF 00000001 00000020 0000303C 0
00006063 00003020 00000001 FFFFFFFF 00000020 00003040 1
00006063 00003024 FFFFFFFF 00000001 00000020 00003044 0
00007063 00003028 FFFFFFFF 00000001 00000020 00003048 1
00007063 0000302C 00000001 FFFFFFFF 00000020 0000304C 0

//--- tb.f
hdl/rv_pkg.sv
hdl/alu.sv
hdl/issue_queue.sv
hdl/executer.sv
hdl/result_queue.sv
hdl/ex_top.sv
tests/ex_top_props.sv
tests/tb_ex_top.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --assert -j 0
TOP       = tb_ex_top
FILELIST  = tb.f
PASS_TEXT = TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
